// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= decoding_graph_tb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+100
PASS_TEXT := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee /dev/stderr | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: build.f
logic/decoder_pkg.sv
logic/neighbor_link.sv
logic/link_mesh.sv
logic/processing_unit.sv
logic/cluster_parity.sv
logic/decoding_graph.sv
tb/decoding_graph_checker.sv
tb/decoding_graph_tb.sv

// File: logic/cluster_parity.sv
`timescale 1ns/10ps

module cluster_parity import decoder_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  pu_state_t [pu_count-1:0]   states_i,
    output logic      [pu_count-1:0]   odd_o
);

    logic [pu_count-1:0] root_parity;   // defect parity per candidate root
    logic [pu_count-1:0] root_boundary; // any member touching a boundary
    logic [pu_count-1:0] odd_next;

    always_comb begin
        root_parity = '0;
        root_boundary = '0;
        for (int k = 0; k < pu_count; k++) begin
            for (int i = 0; i < pu_count; i++) begin
                if (states_i[i].root == pu_addr_of(k)) begin
                    root_parity[k] = root_parity[k] ^ states_i[i].defect;
                    root_boundary[k] = root_boundary[k] | states_i[i].touches_boundary;
                end
            end
        end
    end

    // each unit picks up the verdict of the cluster it belongs to
    always_comb begin
        odd_next = '0;
        for (int i = 0; i < pu_count; i++) begin
            for (int k = 0; k < pu_count; k++) begin
                if (states_i[i].root == pu_addr_of(k)) begin
                    odd_next[i] = root_parity[k] & ~root_boundary[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            odd_o <= '0;
        end else begin
            odd_o <= odd_next;
        end
    end

endmodule

// File: logic/decoder_pkg.sv
package decoder_pkg;

    localparam int grid_width_x = 3; // rows
    localparam int grid_width_z = 3; // columns
    localparam int grid_width_u = 2; // measurement rounds held in the grid
    localparam int plane_size = grid_width_x * grid_width_z;
    localparam int pu_count = plane_size * grid_width_u;
    localparam int neighbor_count = 6;

    localparam int layer_width = $clog2(grid_width_u);
    localparam int row_width = $clog2(grid_width_x);
    localparam int col_width = $clog2(grid_width_z);

    localparam int max_weight = 2; // same weight on every edge
    localparam int link_count_width = $clog2(max_weight + 1);

    localparam int ns_edge_count = (grid_width_x - 1) * grid_width_z * grid_width_u;
    localparam int ew_edge_count = grid_width_x * (grid_width_z - 1) * grid_width_u;
    localparam int ud_edge_count = grid_width_x * grid_width_z * (grid_width_u - 1);
    localparam int edge_count = ns_edge_count + ew_edge_count + ud_edge_count;

    // layer sits on top so the smallest address is found in the oldest round
    typedef struct packed {
        logic [layer_width-1:0] layer;
        logic [row_width-1:0]   row;
        logic [col_width-1:0]   col;
    } pu_addr_t;

    typedef enum logic [1:0] {
        stage_idle,
        stage_measurement_loading,
        stage_grow,
        stage_merge
    } stage_e;

    typedef enum logic [2:0] {
        dir_north,
        dir_south,
        dir_west,
        dir_east,
        dir_down,
        dir_up
    } dir_e;

    typedef struct packed {
        logic     fully_grown;
        logic     is_boundary;
        pu_addr_t far_root; // root seen at the other end
    } link_view_t;

    typedef struct packed {
        pu_addr_t root;
        logic     defect;
        logic     touches_boundary;
    } pu_state_t;

    function automatic int pu_index(input int layer, input int row, input int col);
        return layer * plane_size + row * grid_width_z + col;
    endfunction

    function automatic pu_addr_t pu_addr_of(input int index);
        pu_addr_t addr;
        addr.layer = layer_width'(index / plane_size);
        addr.row = row_width'((index % plane_size) / grid_width_z);
        addr.col = col_width'(index % grid_width_z);
        return addr;
    endfunction

endpackage

// File: logic/decoding_graph.sv
`timescale 1ns/10ps

module decoding_graph import decoder_pkg::*; (
    input  logic                                 clk,
    input  logic                                 reset,
    input  stage_e                               stage_i,
    input  logic [grid_width_x*grid_width_z-1:0] measurements_i,
    input  logic                                 reset_all_edges_i,
    output logic [pu_count-1:0]                  odd_clusters_o,
    output pu_addr_t [pu_count-1:0]              roots_o,
    output logic [pu_count-1:0]                  busy_o,
    output logic [edge_count-1:0]                grown_edges_o
);

    pu_state_t  [pu_count-1:0]                     pu_states;
    link_view_t [pu_count-1:0][neighbor_count-1:0] pu_views;

    genvar gu, gr, gc;

    generate
        for (gu = 0; gu < grid_width_u; gu++) begin : layer
            for (gr = 0; gr < grid_width_x; gr++) begin : row
                for (gc = 0; gc < grid_width_z; gc++) begin : col
                    localparam int p = pu_index(gu, gr, gc);

                    logic measurement;
                    pu_state_t [neighbor_count-1:0] near_states;

                    // new round enters on top and shifts one layer down per load
                    if (gu == grid_width_u - 1)
                        assign measurement = measurements_i[gr * grid_width_z + gc];
                    else assign measurement = pu_states[p + plane_size].defect;

                    if (gr == 0) assign near_states[dir_north] = '0;
                    else assign near_states[dir_north] = pu_states[p - grid_width_z];
                    if (gr == grid_width_x - 1) assign near_states[dir_south] = '0;
                    else assign near_states[dir_south] = pu_states[p + grid_width_z];
                    if (gc == 0) assign near_states[dir_west] = '0;
                    else assign near_states[dir_west] = pu_states[p - 1];
                    if (gc == grid_width_z - 1) assign near_states[dir_east] = '0;
                    else assign near_states[dir_east] = pu_states[p + 1];
                    if (gu == 0) assign near_states[dir_down] = '0;
                    else assign near_states[dir_down] = pu_states[p - plane_size];
                    if (gu == grid_width_u - 1) assign near_states[dir_up] = '0;
                    else assign near_states[dir_up] = pu_states[p + plane_size];

                    processing_unit #(.pu_addr(pu_addr_of(p))) pu_i (
                        .clk(clk),
                        .reset(reset),
                        .stage_i(stage_i),
                        .measurement_i(measurement),
                        .odd_i(odd_clusters_o[p]),
                        .links_i(pu_views[p]),
                        .neighbor_states_i(near_states),
                        .state_o(pu_states[p]),
                        .busy_o(busy_o[p])
                    );

                    assign roots_o[p] = pu_states[p].root;
                end
            end
        end
    endgenerate

    link_mesh link_mesh_i (
        .clk(clk),
        .reset(reset),
        .stage_i(stage_i),
        .reset_all_edges_i(reset_all_edges_i),
        .states_i(pu_states),
        .odd_i(odd_clusters_o), // odd clusters request growth
        .views_o(pu_views),
        .grown_edges_o(grown_edges_o)
    );

    cluster_parity cluster_parity_i (
        .clk(clk),
        .reset(reset),
        .states_i(pu_states),
        .odd_o(odd_clusters_o)
    );

endmodule

// File: logic/link_mesh.sv
`timescale 1ns/10ps

module link_mesh import decoder_pkg::*; (
    input  logic                                           clk,
    input  logic                                           reset,
    input  stage_e                                         stage_i,
    input  logic                                           reset_all_edges_i,
    input  pu_state_t  [pu_count-1:0]                      states_i,
    input  logic       [pu_count-1:0]                      odd_i,
    output link_view_t [pu_count-1:0][neighbor_count-1:0]  views_o,
    output logic       [edge_count-1:0]                    grown_edges_o
);

    localparam int ew_offset = ns_edge_count;
    localparam int ud_offset = ns_edge_count + ew_edge_count;
    localparam int border_count = grid_width_u * grid_width_z;

    // edge numbering inside each direction group
    function automatic int ns_index(input int layer, input int row, input int col);
        return layer * (grid_width_x - 1) * grid_width_z + row * grid_width_z + col;
    endfunction

    function automatic int ew_index(input int layer, input int row, input int col);
        return layer * grid_width_x * (grid_width_z - 1) + row * (grid_width_z - 1) + col;
    endfunction

    function automatic int ud_index(input int layer, input int row, input int col);
        return layer * plane_size + row * grid_width_z + col;
    endfunction

    link_view_t ns_a_view [ns_edge_count]; // a is the north unit
    link_view_t ns_b_view [ns_edge_count];
    link_view_t ew_a_view [ew_edge_count]; // a is the west unit
    link_view_t ew_b_view [ew_edge_count];
    link_view_t ud_a_view [ud_edge_count]; // a is the lower layer
    link_view_t ud_b_view [ud_edge_count];
    link_view_t border_view [2 * border_count]; // all north edges come before the south edges

    genvar gu, gr, gc;

    generate
        for (gu = 0; gu < grid_width_u; gu++) begin : layer
            for (gr = 0; gr < grid_width_x; gr++) begin : row
                for (gc = 0; gc < grid_width_z; gc++) begin : col
                    localparam int p = pu_index(gu, gr, gc);
                    localparam int north_slot = gu * grid_width_z + gc;
                    localparam int south_slot = border_count + north_slot;

                    if (gr < grid_width_x - 1) begin : ns
                        neighbor_link #(.boundary_link(1'b0)) link_i (
                            .clk(clk), .reset(reset), .stage_i(stage_i),
                            .reset_all_edges_i(reset_all_edges_i),
                            .a_odd_i(odd_i[p]), .b_odd_i(odd_i[p + grid_width_z]),
                            .a_root_i(states_i[p].root),
                            .b_root_i(states_i[p + grid_width_z].root),
                            .a_view_o(ns_a_view[ns_index(gu, gr, gc)]),
                            .b_view_o(ns_b_view[ns_index(gu, gr, gc)]),
                            .fully_grown_o(grown_edges_o[ns_index(gu, gr, gc)])
                        );
                    end
                    if (gc < grid_width_z - 1) begin : ew
                        neighbor_link #(.boundary_link(1'b0)) link_i (
                            .clk(clk), .reset(reset), .stage_i(stage_i),
                            .reset_all_edges_i(reset_all_edges_i),
                            .a_odd_i(odd_i[p]), .b_odd_i(odd_i[p + 1]),
                            .a_root_i(states_i[p].root), .b_root_i(states_i[p + 1].root),
                            .a_view_o(ew_a_view[ew_index(gu, gr, gc)]),
                            .b_view_o(ew_b_view[ew_index(gu, gr, gc)]),
                            .fully_grown_o(grown_edges_o[ew_offset + ew_index(gu, gr, gc)])
                        );
                    end
                    if (gu < grid_width_u - 1) begin : ud
                        neighbor_link #(.boundary_link(1'b0)) link_i (
                            .clk(clk), .reset(reset), .stage_i(stage_i),
                            .reset_all_edges_i(reset_all_edges_i),
                            .a_odd_i(odd_i[p]), .b_odd_i(odd_i[p + plane_size]),
                            .a_root_i(states_i[p].root),
                            .b_root_i(states_i[p + plane_size].root),
                            .a_view_o(ud_a_view[ud_index(gu, gr, gc)]),
                            .b_view_o(ud_b_view[ud_index(gu, gr, gc)]),
                            .fully_grown_o(grown_edges_o[ud_offset + ud_index(gu, gr, gc)])
                        );
                    end
                    // north edge of row 0 and south edge of the last row end on the boundary
                    if (gr == 0 || gr == grid_width_x - 1) begin : border
                        neighbor_link #(.boundary_link(1'b1)) link_i (
                            .clk(clk), .reset(reset), .stage_i(stage_i),
                            .reset_all_edges_i(reset_all_edges_i),
                            .a_odd_i(odd_i[p]), .b_odd_i(1'b0),
                            .a_root_i(states_i[p].root), .b_root_i('0),
                            .a_view_o(border_view[gr == 0 ? north_slot : south_slot]),
                            .b_view_o(), .fully_grown_o()
                        );
                    end

                    // steer link ends into the unit's direction slots
                    if (gr == 0) assign views_o[p][dir_north] = border_view[north_slot];
                    else assign views_o[p][dir_north] = ns_b_view[ns_index(gu, gr - 1, gc)];
                    if (gr == grid_width_x - 1)
                        assign views_o[p][dir_south] = border_view[south_slot];
                    else assign views_o[p][dir_south] = ns_a_view[ns_index(gu, gr, gc)];
                    if (gc == 0) assign views_o[p][dir_west] = '0; // no link past the row end
                    else assign views_o[p][dir_west] = ew_b_view[ew_index(gu, gr, gc - 1)];
                    if (gc == grid_width_z - 1) assign views_o[p][dir_east] = '0;
                    else assign views_o[p][dir_east] = ew_a_view[ew_index(gu, gr, gc)];
                    if (gu == 0) assign views_o[p][dir_down] = '0;
                    else assign views_o[p][dir_down] = ud_b_view[ud_index(gu - 1, gr, gc)];
                    if (gu == grid_width_u - 1) assign views_o[p][dir_up] = '0;
                    else assign views_o[p][dir_up] = ud_a_view[ud_index(gu, gr, gc)];
                end
            end
        end
    endgenerate

endmodule

// File: logic/neighbor_link.sv
`timescale 1ns/10ps

module neighbor_link import decoder_pkg::*; #(
    parameter bit boundary_link = 1'b0
) (
    input  logic       clk,
    input  logic       reset,
    input  stage_e     stage_i,
    input  logic       reset_all_edges_i,
    input  logic       a_odd_i,
    input  logic       b_odd_i,
    input  pu_addr_t   a_root_i,
    input  pu_addr_t   b_root_i,
    output link_view_t a_view_o,
    output link_view_t b_view_o,
    output logic       fully_grown_o
);

    logic [link_count_width-1:0] growth_q;
    logic [link_count_width-1:0] grow_step;
    logic [link_count_width:0]   growth_sum;

    // one step per odd end, a boundary link has only the a end
    always_comb begin
        grow_step = {{(link_count_width-1){1'b0}}, a_odd_i};
        if (!boundary_link) begin
            grow_step = grow_step + {{(link_count_width-1){1'b0}}, b_odd_i};
        end
    end

    assign growth_sum = {1'b0, growth_q} + {1'b0, grow_step};

    always_ff @(posedge clk) begin
        if (reset) begin
            growth_q <= '0;
        end else if (reset_all_edges_i || stage_i == stage_measurement_loading) begin
            growth_q <= '0;
        end else if (stage_i == stage_grow) begin
            if (growth_sum >= (link_count_width + 1)'(max_weight)) begin
                growth_q <= link_count_width'(max_weight); // saturate
            end else begin
                growth_q <= growth_sum[link_count_width-1:0];
            end
        end
    end

    assign fully_grown_o = (growth_q == link_count_width'(max_weight));

    always_comb begin
        a_view_o.fully_grown = fully_grown_o;
        a_view_o.is_boundary = boundary_link;
        a_view_o.far_root = boundary_link ? a_root_i : b_root_i;
        b_view_o.fully_grown = boundary_link ? 1'b0 : fully_grown_o;
        b_view_o.is_boundary = 1'b0;
        b_view_o.far_root = a_root_i;
    end

endmodule

// File: logic/processing_unit.sv
`timescale 1ns/10ps

module processing_unit import decoder_pkg::*; #(
    parameter pu_addr_t pu_addr = '0
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  stage_e                                 stage_i,
    input  logic                                   measurement_i,
    input  logic                                   odd_i,
    input  link_view_t [neighbor_count-1:0]        links_i,
    input  pu_state_t  [neighbor_count-1:0]        neighbor_states_i,
    output pu_state_t                              state_o,
    output logic                                   busy_o
);

    logic     defect_q;
    pu_addr_t root_q;
    logic     boundary_q;

    pu_addr_t root_next;
    logic     boundary_next;

    // minimum root and boundary contact over all fully grown links
    always_comb begin
        root_next = root_q;
        boundary_next = boundary_q;
        for (int d = 0; d < neighbor_count; d++) begin
            if (links_i[d].fully_grown) begin
                if (links_i[d].is_boundary) begin
                    // a boundary only absorbs a cluster that still needs pairing
                    if (odd_i) begin
                        boundary_next = 1'b1;
                    end
                end else begin
                    if (links_i[d].far_root < root_next) begin
                        root_next = links_i[d].far_root;
                    end
                    if (neighbor_states_i[d].touches_boundary) begin
                        boundary_next = 1'b1; // contact spreads across the cluster
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            defect_q <= 1'b0;
            root_q <= pu_addr;
            boundary_q <= 1'b0;
        end else begin
            case (stage_i)
                stage_measurement_loading: begin
                    defect_q <= measurement_i;
                    root_q <= pu_addr; // every unit restarts as its own cluster
                    boundary_q <= 1'b0;
                end
                stage_merge: begin
                    root_q <= root_next;
                    boundary_q <= boundary_next;
                end
                default: begin
                end
            endcase
        end
    end

    // high while this edge still changes the unit
    assign busy_o = (stage_i == stage_merge) &&
                    ((root_next != root_q) || (boundary_next != boundary_q));

    assign state_o.root = root_q;
    assign state_o.defect = defect_q; // also feeds the layer below
    assign state_o.touches_boundary = boundary_q;

endmodule

// File: tb/decoding_graph_checker.sv
`timescale 1ns/10ps

module decoding_graph_checker import decoder_pkg::*; (
    input logic                  clk,
    input logic                  reset,
    input stage_e                stage_i,
    input logic [pu_count-1:0]   busy_i,
    input logic [pu_count-1:0]   odd_clusters_i,
    input logic [edge_count-1:0] grown_edges_i
);

    int failure_count = 0; // failed assertions so far

    // units only change during merge
    busy_outside_merge: assert property (@(posedge clk) disable iff (reset)
        stage_i != stage_merge |-> busy_i == '0)
        else begin
            failure_count++;
            $error("busy raised outside the merge stage");
        end

    edges_after_load: assert property (@(posedge clk) disable iff (reset)
        stage_i == stage_measurement_loading |=> grown_edges_i == '0)
        else begin
            failure_count++;
            $error("grown edges left after a loading cycle");
        end

    odd_after_reset: assert property (@(posedge clk)
        $fell(reset) |=> odd_clusters_i == '0)
        else begin
            failure_count++;
            $error("odd clusters set right after reset");
        end

endmodule

// File: tb/decoding_graph_tb.sv
`timescale 1ns/10ps

module decoding_graph_tb import decoder_pkg::*; ();

    // six tests of at most about 40 cycles each plus reset, with a wide margin
    localparam int timeout_cycles = 2000;
    localparam int merge_limit = 50;
    localparam int pair_edge = ns_edge_count + (grid_width_z - 1); // EW edge, layer 0 row 1 col 0

    logic                    clk;
    logic                    reset;
    stage_e                  stage;
    logic [plane_size-1:0]   measurements;
    logic                    reset_all_edges;
    logic [pu_count-1:0]     odd_clusters;
    pu_addr_t [pu_count-1:0] roots;
    logic [pu_count-1:0]     busy;
    logic [edge_count-1:0]   grown_edges;

    int seed;
    int cycle_count = 0;
    int errors;
    int assertion_failures;
    int tests_passed;
    int tests_failed;

    decoding_graph decoding_graph_i (
        .clk(clk),
        .reset(reset),
        .stage_i(stage),
        .measurements_i(measurements),
        .reset_all_edges_i(reset_all_edges),
        .odd_clusters_o(odd_clusters),
        .roots_o(roots),
        .busy_o(busy),
        .grown_edges_o(grown_edges)
    );

    bind decoding_graph decoding_graph_checker checker_i (
        .clk(clk), .reset(reset), .stage_i(stage_i), .busy_i(busy_o),
        .odd_clusters_i(odd_clusters_o), .grown_edges_i(grown_edges_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // unit order on the outputs is layer, then row, then column
    function automatic int unit_index(input int layer, input int row, input int col);
        return layer * plane_size + row * grid_width_z + col;
    endfunction

    function automatic pu_addr_t unit_address(input int layer, input int row, input int col);
        pu_addr_t addr;
        addr.layer = layer[layer_width-1:0];
        addr.row = row[row_width-1:0];
        addr.col = col[col_width-1:0];
        return addr;
    endfunction

    task automatic flag_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic check_own_roots(input string when);
        for (int l = 0; l < grid_width_u; l++) begin
            for (int r = 0; r < grid_width_x; r++) begin
                for (int c = 0; c < grid_width_z; c++) begin
                    if (roots[unit_index(l, r, c)] != unit_address(l, r, c))
                        flag_error($sformatf("unit %0d root %h %s, expected %h",
                            unit_index(l, r, c), roots[unit_index(l, r, c)], when,
                            unit_address(l, r, c)));
                end
            end
        end
    endtask

    task automatic load_round(input logic [plane_size-1:0] pattern);
        @(posedge clk);
        stage <= stage_measurement_loading;
        measurements <= pattern;
        @(posedge clk);
        stage <= stage_idle;
        @(posedge clk); // odd bits follow the new defects one cycle later
    endtask

    task automatic grow(input int cycles);
        @(posedge clk);
        stage <= stage_grow;
        repeat (cycles) @(posedge clk);
        stage <= stage_idle;
    endtask

    task automatic merge_until_settled;
        int cycles;
        cycles = 0;
        @(posedge clk);
        stage <= stage_merge;
        @(negedge clk);
        while (busy != '0 && cycles < merge_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (busy != '0) begin
            $display("merge did not settle within %0d cycles", merge_limit);
            errors++;
        end
        @(posedge clk);
        stage <= stage_idle;
        @(negedge clk); // registered odd bits now match the settled clusters
    endtask

    task automatic run_pair;
        logic [plane_size-1:0] pair;
        pair = '0;
        pair[1 * grid_width_z + 0] = 1'b1;
        pair[1 * grid_width_z + 1] = 1'b1;
        load_round(pair);
        load_round('0); // pair moves down to layer 0
        grow(1);
        merge_until_settled();
    endtask

    task automatic test_reset_state;
        int start;
        start = errors;
        @(negedge clk);
        check_own_roots("after reset");
        if (busy != '0) flag_error($sformatf("busy %h after reset", busy));
        if (odd_clusters != '0) flag_error($sformatf("odd %h after reset", odd_clusters));
        if (grown_edges != '0) flag_error($sformatf("edges %h after reset", grown_edges));
        finish_test("reset state", start);
    endtask

    task automatic test_loading_shift;
        int start;
        logic [31:0] rnd;
        logic [plane_size-1:0] pattern_a;
        logic [plane_size-1:0] pattern_b;
        start = errors;
        rnd = $random(seed);
        pattern_a = rnd[plane_size-1:0];
        rnd = $random(seed);
        pattern_b = rnd[plane_size-1:0];
        load_round(pattern_a);
        load_round(pattern_b);
        @(negedge clk);
        if (odd_clusters[plane_size-1:0] != pattern_a)
            flag_error($sformatf("layer 0 odd %h, expected %h",
                odd_clusters[plane_size-1:0], pattern_a));
        if (odd_clusters[pu_count-1:plane_size] != pattern_b)
            flag_error($sformatf("layer 1 odd %h, expected %h",
                odd_clusters[pu_count-1:plane_size], pattern_b));
        check_own_roots("after loading");
        finish_test("loading shift", start);
    endtask

    task automatic test_adjacent_pair;
        int start;
        logic [edge_count-1:0] expected_edges;
        start = errors;
        expected_edges = '0;
        expected_edges[pair_edge] = 1'b1;
        run_pair();
        if (roots[unit_index(0, 1, 0)] != unit_address(0, 1, 0))
            flag_error($sformatf("left root %h", roots[unit_index(0, 1, 0)]));
        if (roots[unit_index(0, 1, 1)] != unit_address(0, 1, 0))
            flag_error($sformatf("right root %h", roots[unit_index(0, 1, 1)]));
        if (odd_clusters[unit_index(0, 1, 0)] || odd_clusters[unit_index(0, 1, 1)])
            flag_error("paired defects still odd");
        if (grown_edges != expected_edges)
            flag_error($sformatf("edges %h, expected %h", grown_edges, expected_edges));
        finish_test("adjacent pair", start);
    endtask

    task automatic test_boundary;
        int start;
        logic [plane_size-1:0] single;
        start = errors;
        single = '0;
        single[0] = 1'b1; // column 0 keeps the smallest address, so the root stays put
        load_round(single);
        load_round('0);
        grow(1);
        merge_until_settled();
        if (!odd_clusters[unit_index(0, 0, 0)]) flag_error("defect not odd after one grow");
        if (grown_edges != '0) flag_error($sformatf("edges %h after one grow", grown_edges));
        grow(1);
        merge_until_settled();
        if (odd_clusters[unit_index(0, 0, 0)]) flag_error("defect still odd at boundary");
        if (roots[unit_index(0, 0, 0)] != unit_address(0, 0, 0))
            flag_error($sformatf("root %h changed", roots[unit_index(0, 0, 0)]));
        finish_test("boundary termination", start);
    endtask

    task automatic test_isolated;
        int start;
        logic [plane_size-1:0] single;
        start = errors;
        single = '0;
        single[1 * grid_width_z + 1] = 1'b1;
        load_round('0);
        load_round(single); // lands in the top layer
        grow(1);
        merge_until_settled();
        if (!odd_clusters[unit_index(1, 1, 1)]) flag_error("isolated defect not odd");
        if (grown_edges != '0) flag_error($sformatf("edges %h, expected 0", grown_edges));
        finish_test("isolated defect", start);
    endtask

    task automatic test_edge_clear;
        int start;
        start = errors;
        run_pair();
        if (grown_edges == '0) flag_error("no grown edge before clear");
        @(posedge clk);
        reset_all_edges <= 1'b1;
        @(posedge clk);
        reset_all_edges <= 1'b0;
        @(negedge clk);
        if (grown_edges != '0) flag_error($sformatf("edges %h after clear", grown_edges));
        finish_test("edge clear", start);
    endtask

    initial begin
        seed = 32'hed94;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        reset = 1'b1;
        stage = stage_idle;
        measurements = '0;
        reset_all_edges = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        test_reset_state();
        test_loading_shift();
        test_adjacent_pair();
        test_boundary();
        test_isolated();
        test_edge_clear();

        assertion_failures = decoding_graph_i.checker_i.failure_count;
        $display("tests passed: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
            tests_passed, tests_failed, errors, assertion_failures);
        if (errors == 0 && tests_failed == 0 && assertion_failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
